/* hw/core_pkg.sv */
/*
  Core-internal types: alu operation codes, control flags and the
  structs passed between fetch, the IF/ID buffer and execute.
  Also holds the reset pc and the data memory size.
*/
package core_pkg;

  typedef enum logic [4:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b,
    // compare results, used by branches
    alu_eq,
    alu_ne,
    alu_lt,
    alu_ge,
    alu_ltu,
    alu_geu
  } alu_op_t;

  typedef struct packed {
    alu_op_t alu_op;
    logic    use_imm;
    logic    pc_operand;
    logic    reg_wen;
    logic    mem_wen;
    logic    is_load;
    logic    is_branch;
    logic    is_jal;
    logic    is_jalr;
    logic    is_ebreak;
    logic    illegal;
  } ctrl_t;

  typedef struct packed {
    isa_pkg::word_t pc;
    isa_pkg::inst_u inst;
  } fetch_t;

  typedef struct packed {
    isa_pkg::reg_idx_t rd;
    isa_pkg::reg_idx_t rs1;
    isa_pkg::reg_idx_t rs2;
    isa_pkg::word_t    imm;
    ctrl_t             ctrl;
  } decoded_t;

  // reported once per register write
  typedef struct packed {
    isa_pkg::word_t    pc;
    isa_pkg::reg_idx_t rd;
    isa_pkg::word_t    wdata;
  } retire_t;

  localparam isa_pkg::word_t pc_reset = 32'h0000_0000;

  localparam int dmem_words     = 256;
  localparam int dmem_idx_width = $clog2(dmem_words);

endpackage

/* hw/core_top.sv */
/*
  Top level of the RV32I core. Fetch feeds the IF/ID buffer, which
  feeds execute. Instruction memory sits outside on the imem port;
  retire, halt and illegal report progress to the testbench.
*/
`timescale 1ns/1ps

module core_top (
  input  logic              clk,
  input  logic              reset,
  output isa_pkg::word_t    imem_addr,
  input  isa_pkg::word_t    imem_data,
  output logic              retire_valid,
  output core_pkg::retire_t retire,
  output logic              halt,
  output logic              illegal
);

  import isa_pkg::*;
  import core_pkg::*;

  fetch_t fetch;
  fetch_t stage;
  logic   redirect;
  word_t  redirect_pc;

  fetch_unit u_fetch_unit (
    .clk         (clk),
    .reset       (reset),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .halt        (halt),
    .fetch       (fetch),
    .imem_addr   (imem_addr),
    .imem_data   (imem_data)
  );

  // a redirect also flushes the slot fetched on the wrong path
  if_id_reg u_if_id_reg (
    .clk       (clk),
    .reset     (reset),
    .flush     (redirect),
    .hold      (halt),
    .fetch_in  (fetch),
    .fetch_out (stage)
  );

  execute_unit u_execute_unit (
    .clk          (clk),
    .reset        (reset),
    .stage        (stage),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc),
    .retire_valid (retire_valid),
    .retire       (retire),
    .halt         (halt),
    .illegal      (illegal)
  );

endmodule

/* hw/data_memory.sv */
/*
  Data RAM for lw and sw. Word addressed from the byte address,
  wrapping at the memory depth. Reads are combinational, writes
  land at the clock edge.
*/
`timescale 1ns/1ps

module data_memory (
  input  logic           clk,
  input  isa_pkg::word_t addr,
  input  isa_pkg::word_t wdata,
  input  logic           wen,
  output isa_pkg::word_t rdata
);

  import isa_pkg::*;
  import core_pkg::*;

  word_t                     mem [dmem_words];
  logic [dmem_idx_width-1:0] idx;

  // byte offset dropped, upper bits wrap
  assign idx = addr[dmem_idx_width+1:2];

  always_ff @(posedge clk) begin
    if (wen) begin
      mem[idx] <= wdata;
    end
  end

  assign rdata = mem[idx];

endmodule

/* hw/decoder.sv */
/*
  Instruction decoder. Reads the buffered word through the format
  view its opcode selects, builds the sign-extended immediate and
  the control flags. Unknown encodings raise illegal with no writes.
*/
`timescale 1ns/1ps

module decoder (
  input  isa_pkg::inst_u      inst,
  output core_pkg::decoded_t  decoded
);

  import isa_pkg::*;
  import core_pkg::*;

  function automatic alu_op_t alu_from_funct3(input logic [2:0] f3, input logic alt);
    alu_op_t op_sel;
    case (f3)
      f3_add:  op_sel = alt ? alu_sub : alu_add;
      f3_sll:  op_sel = alu_sll;
      f3_slt:  op_sel = alu_slt;
      f3_sltu: op_sel = alu_sltu;
      f3_xor:  op_sel = alu_xor;
      f3_srl:  op_sel = alt ? alu_sra : alu_srl;
      f3_or:   op_sel = alu_or;
      default: op_sel = alu_and;
    endcase
    return op_sel;
  endfunction

  function automatic alu_op_t cmp_from_funct3(input logic [2:0] f3);
    alu_op_t op_sel;
    case (f3)
      f3_beq:  op_sel = alu_eq;
      f3_bne:  op_sel = alu_ne;
      f3_blt:  op_sel = alu_lt;
      f3_bge:  op_sel = alu_ge;
      f3_bltu: op_sel = alu_ltu;
      default: op_sel = alu_geu;
    endcase
    return op_sel;
  endfunction

  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_u;
  word_t imm_j;

  assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
  assign imm_s = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
  assign imm_b = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                  inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
  assign imm_u = {inst.u.imm, 12'h000};
  assign imm_j = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                  inst.j.imm_11, inst.j.imm_10_1, 1'b0};

  always_comb begin
    decoded             = '0;
    decoded.rd          = inst.r.rd;
    decoded.rs1         = inst.r.rs1;
    decoded.rs2         = inst.r.rs2;
    decoded.ctrl.alu_op = alu_add;

    case (inst.r.opcode)
      opc_op: begin
        decoded.ctrl.alu_op  = alu_from_funct3(inst.r.funct3, inst.r.funct7 == f7_alt);
        decoded.ctrl.reg_wen = 1'b1;
      end
      opc_op_imm: begin
        // addi has no sub form, only srai uses the alt bit
        decoded.ctrl.alu_op  = alu_from_funct3(inst.i.funct3,
            inst.i.funct3 == f3_srl && inst.r.funct7 == f7_alt);
        decoded.imm          = imm_i;
        decoded.ctrl.use_imm = 1'b1;
        decoded.ctrl.reg_wen = 1'b1;
      end
      opc_lui: begin
        decoded.ctrl.alu_op  = alu_pass_b;
        decoded.imm          = imm_u;
        decoded.ctrl.use_imm = 1'b1;
        decoded.ctrl.reg_wen = 1'b1;
      end
      opc_auipc: begin
        decoded.imm             = imm_u;
        decoded.ctrl.use_imm    = 1'b1;
        decoded.ctrl.pc_operand = 1'b1;
        decoded.ctrl.reg_wen    = 1'b1;
      end
      opc_jal: begin
        decoded.imm             = imm_j;
        decoded.ctrl.use_imm    = 1'b1;
        decoded.ctrl.pc_operand = 1'b1;
        decoded.ctrl.reg_wen    = 1'b1;
        decoded.ctrl.is_jal     = 1'b1;
      end
      opc_jalr: begin
        decoded.imm          = imm_i;
        decoded.ctrl.use_imm = 1'b1;
        decoded.ctrl.reg_wen = 1'b1;
        decoded.ctrl.is_jalr = 1'b1;
      end
      opc_branch: begin
        decoded.ctrl.alu_op    = cmp_from_funct3(inst.b.funct3);
        decoded.imm            = imm_b;
        decoded.ctrl.is_branch = 1'b1;
      end
      opc_load: begin
        decoded.imm          = imm_i;
        decoded.ctrl.use_imm = 1'b1;
        decoded.ctrl.is_load = 1'b1;
        decoded.ctrl.reg_wen = inst.i.funct3 == f3_word;
        decoded.ctrl.illegal = inst.i.funct3 != f3_word;
      end
      opc_store: begin
        decoded.imm          = imm_s;
        decoded.ctrl.use_imm = 1'b1;
        decoded.ctrl.mem_wen = inst.s.funct3 == f3_word;
        decoded.ctrl.illegal = inst.s.funct3 != f3_word;
      end
      opc_system: begin
        // ebreak is the only system instruction handled here
        decoded.ctrl.is_ebreak = inst.i.imm == ebreak_imm && inst.i.funct3 == 3'd0;
        decoded.ctrl.illegal   = !decoded.ctrl.is_ebreak;
      end
      default: begin
        decoded.ctrl.illegal = 1'b1;
      end
    endcase
  end

endmodule

/* hw/execute_unit.sv */
/*
  Execute stage. Decodes the buffered instruction, reads registers,
  runs the alu, resolves branches and jumps, accesses data memory
  and writes back, all in one cycle. Drives the redirect to fetch
  and reports each register write on the retire port.
*/
`timescale 1ns/1ps

module execute_unit (
  input  logic              clk,
  input  logic              reset,
  input  core_pkg::fetch_t  stage,
  output logic              redirect,
  output isa_pkg::word_t    redirect_pc,
  output logic              retire_valid,
  output core_pkg::retire_t retire,
  output logic              halt,
  output logic              illegal
);

  import isa_pkg::*;
  import core_pkg::*;

  decoded_t dec;
  word_t    rs1_data;
  word_t    rs2_data;
  word_t    op_a;
  word_t    op_b;
  word_t    alu_result;
  word_t    mem_rdata;
  word_t    wdata;
  word_t    pc_plus4;
  logic     taken;
  logic     halt_q;
  logic     illegal_q;

  decoder u_decoder (
    .inst    (stage.inst),
    .decoded (dec)
  );

  register_file #(
    .addr_width ($bits(reg_idx_t)),
    .data_width (xlen)
  ) u_register_file (
    .clk     (clk),
    .wen     (dec.ctrl.reg_wen),
    .waddr   (dec.rd),
    .wdata   (wdata),
    .raddr_a (dec.rs1),
    .raddr_b (dec.rs2),
    .rdata_a (rs1_data),
    .rdata_b (rs2_data)
  );

  // store data comes straight from rs2
  data_memory u_data_memory (
    .clk   (clk),
    .addr  (alu_result),
    .wdata (rs2_data),
    .wen   (dec.ctrl.mem_wen),
    .rdata (mem_rdata)
  );

  assign op_a = dec.ctrl.pc_operand ? stage.pc : rs1_data;
  assign op_b = dec.ctrl.use_imm ? dec.imm : rs2_data;

  always_comb begin
    case (dec.ctrl.alu_op)
      alu_add:    alu_result = op_a + op_b;
      alu_sub:    alu_result = op_a - op_b;
      alu_sll:    alu_result = op_a << op_b[4:0];
      alu_slt:    alu_result = word_t'($signed(op_a) < $signed(op_b));
      alu_sltu:   alu_result = word_t'(op_a < op_b);
      alu_xor:    alu_result = op_a ^ op_b;
      alu_srl:    alu_result = op_a >> op_b[4:0];
      alu_sra:    alu_result = $signed(op_a) >>> op_b[4:0];
      alu_or:     alu_result = op_a | op_b;
      alu_and:    alu_result = op_a & op_b;
      alu_pass_b: alu_result = op_b;
      alu_eq:     alu_result = word_t'(op_a == op_b);
      alu_ne:     alu_result = word_t'(op_a != op_b);
      alu_lt:     alu_result = word_t'($signed(op_a) < $signed(op_b));
      alu_ge:     alu_result = word_t'($signed(op_a) >= $signed(op_b));
      alu_ltu:    alu_result = word_t'(op_a < op_b);
      alu_geu:    alu_result = word_t'(op_a >= op_b);
      default:    alu_result = '0;
    endcase
  end

  assign pc_plus4 = stage.pc + 32'd4;

  // alu gives the compare result for branches, the target sum for jumps
  assign taken       = dec.ctrl.is_branch && alu_result[0];
  assign redirect    = taken || dec.ctrl.is_jal || dec.ctrl.is_jalr;
  assign redirect_pc = dec.ctrl.is_branch ? stage.pc + dec.imm : alu_result & ~word_t'(1);

  always_comb begin
    if (dec.ctrl.is_jal || dec.ctrl.is_jalr) begin
      wdata = pc_plus4;
    end else if (dec.ctrl.is_load) begin
      wdata = mem_rdata;
    end else begin
      wdata = alu_result;
    end
  end

  assign retire_valid = dec.ctrl.reg_wen && dec.rd != '0;
  assign retire.pc    = stage.pc;
  assign retire.rd    = dec.rd;
  assign retire.wdata = wdata;

  // both status levels stick once raised
  always_ff @(posedge clk) begin
    if (reset) begin
      halt_q    <= 1'b0;
      illegal_q <= 1'b0;
    end else begin
      halt_q    <= halt;
      illegal_q <= illegal;
    end
  end

  assign halt    = halt_q || dec.ctrl.is_ebreak;
  assign illegal = illegal_q || dec.ctrl.illegal;

endmodule

/* hw/fetch_unit.sv */
/*
  Fetch stage. Holds the program counter, drives the instruction
  address and pairs the returned word with its pc for the buffer.
  The pc steps by 4, takes the redirect target, or freezes on halt.
*/
`timescale 1ns/1ps

module fetch_unit (
  input  logic             clk,
  input  logic             reset,
  input  logic             redirect,
  input  isa_pkg::word_t   redirect_pc,
  input  logic             halt,
  output core_pkg::fetch_t fetch,
  output isa_pkg::word_t   imem_addr,
  input  isa_pkg::word_t   imem_data
);

  import isa_pkg::*;
  import core_pkg::*;

  word_t pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= pc_reset;
    end else if (halt) begin
      // core stopped on ebreak
      pc <= pc;
    end else if (redirect) begin
      pc <= redirect_pc;
    end else begin
      pc <= pc + 32'd4;
    end
  end

  assign imem_addr  = pc;

  // rom is read combinationally, so the word belongs to this pc
  assign fetch.pc   = pc;
  assign fetch.inst = imem_data;

endmodule

/* hw/if_id_reg.sv */
/*
  Buffer between fetch and execute. Captures the fetched pc and
  instruction each cycle. A flush turns the slot into a bubble,
  and hold keeps the current instruction while the core is halted.
*/
`timescale 1ns/1ps

module if_id_reg (
  input  logic             clk,
  input  logic             reset,
  input  logic             flush,
  input  logic             hold,
  input  core_pkg::fetch_t fetch_in,
  output core_pkg::fetch_t fetch_out
);

  import isa_pkg::*;
  import core_pkg::*;

  always_ff @(posedge clk) begin
    if (reset) begin
      fetch_out.pc   <= pc_reset;
      fetch_out.inst <= nop_word;
    end else if (hold) begin
      fetch_out <= fetch_out;
    end else if (flush) begin
      // wrong-path instruction after a taken transfer
      fetch_out.pc   <= fetch_in.pc;
      fetch_out.inst <= nop_word;
    end else begin
      fetch_out <= fetch_in;
    end
  end

endmodule

/* hw/isa_pkg.sv */
/*
  RV32I instruction set definitions shared by the core.
  Major opcodes, funct fields and the bit layout of each format,
  plus a union that lets one word be read through any format view.
*/
package isa_pkg;

  localparam int xlen = 32;

  typedef logic [4:0]      reg_idx_t;
  typedef logic [xlen-1:0] word_t;

  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_system = 7'b1110011
  } opcode_t;

  // funct3 of register and immediate alu operations
  localparam logic [2:0] f3_add  = 3'd0;
  localparam logic [2:0] f3_sll  = 3'd1;
  localparam logic [2:0] f3_slt  = 3'd2;
  localparam logic [2:0] f3_sltu = 3'd3;
  localparam logic [2:0] f3_xor  = 3'd4;
  localparam logic [2:0] f3_srl  = 3'd5;
  localparam logic [2:0] f3_or   = 3'd6;
  localparam logic [2:0] f3_and  = 3'd7;

  // funct3 of branches
  localparam logic [2:0] f3_beq  = 3'd0;
  localparam logic [2:0] f3_bne  = 3'd1;
  localparam logic [2:0] f3_blt  = 3'd4;
  localparam logic [2:0] f3_bge  = 3'd5;
  localparam logic [2:0] f3_bltu = 3'd6;
  localparam logic [2:0] f3_bgeu = 3'd7;

  // word size for lw and sw
  localparam logic [2:0] f3_word = 3'd2;

  // bit 5 of funct7 selects sub and sra
  localparam logic [6:0] f7_alt = 7'b0100000;

  localparam logic [11:0] ebreak_imm = 12'h001;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    opcode_t    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    opcode_t     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_t    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_t    opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    reg_idx_t    rd;
    opcode_t     opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    reg_idx_t   rd;
    opcode_t    opcode;
  } j_fmt_t;

  typedef union packed {
    word_t  raw;
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } inst_u;

  // addi x0, x0, 0
  localparam word_t nop_word = 32'h0000_0013;

endpackage

/* hw/register_file.sv */
/*
  General purpose register file. Two combinational read ports and
  one write port that commits at the clock edge. x0 reads as zero.
*/
`timescale 1ns/1ps

module register_file #(
  parameter int addr_width = 5,
  parameter int data_width = 32
) (
  input  logic                  clk,
  input  logic                  wen,
  input  logic [addr_width-1:0] waddr,
  input  logic [data_width-1:0] wdata,
  input  logic [addr_width-1:0] raddr_a,
  input  logic [addr_width-1:0] raddr_b,
  output logic [data_width-1:0] rdata_a,
  output logic [data_width-1:0] rdata_b
);

  logic [data_width-1:0] regs [2**addr_width];

  always_ff @(posedge clk) begin
    if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // entry 0 is never written
  assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
  assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

/* project.f */
hw/isa_pkg.sv
hw/core_pkg.sv
hw/fetch_unit.sv
hw/if_id_reg.sv
hw/decoder.sv
hw/register_file.sv
hw/data_memory.sv
hw/execute_unit.sv
hw/core_top.sv
verification/clock_gen.sv
verification/core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the core testbench with Verilator, runs it from the project root
# and reports success only if the pass message appears in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module core_tb -f project.f -o core_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/core_sim)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "test passed"; then
  exit 0
else
  exit 1
fi

/* verification/clock_gen.sv */
/*
  Testbench clock and reset source for the core.
  Free-running 40 ns clock; reset is held for the first 4 rising
  edges and released 1 ns after the last of them.
*/
`timescale 1ns/1ps

module clock_gen (
  output logic clk,
  output logic reset
);

  localparam int half_period_ns = 20;
  localparam int reset_cycles   = 4;

  initial begin
    clk = 1'b0;
    forever #(half_period_ns) clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule

/* verification/core_stimulus.txt */
# P <byte addr> <instruction word>   E <pc> <rd> <write value>   H <ebreak pc>
# all values hex; program words not listed hold an illegal filler
# alu, lui, auipc
P 00000000 00500093  addi x1, x0, 5
P 00000004 ffd00113  addi x2, x0, -3
P 00000008 002081b3  add x3, x1, x2
P 0000000c 40208233  sub x4, x1, x2
P 00000010 800002b7  lui x5, 0x80000
P 00000014 4042d313  srai x6, x5, 4
P 00000018 0042d393  srli x7, x5, 4
P 0000001c 00112433  slt x8, x2, x1
P 00000020 001134b3  sltu x9, x2, x1
P 00000024 fff0c513  xori x10, x1, -1
P 00000028 00001597  auipc x11, 1
# memory and x0
P 0000002c 04202023  sw x2, 64(x0)
P 00000030 04002603  lw x12, 64(x0)
P 00000034 00708013  addi x0, x1, 7
P 00000038 000006b3  add x13, x0, x0
# branches, each kind untaken then taken over a filler slot
P 0000003c 00208463  beq x1, x2, 8
P 00000040 00108463  beq x1, x1, 8
P 00000048 00109463  bne x1, x1, 8
P 0000004c 00209463  bne x1, x2, 8
P 00000054 0020c463  blt x1, x2, 8
P 00000058 00114463  blt x2, x1, 8
P 00000060 00115463  bge x2, x1, 8
P 00000064 0020d463  bge x1, x2, 8
P 0000006c 00116463  bltu x2, x1, 8
P 00000070 0020e463  bltu x1, x2, 8
P 00000078 0020f463  bgeu x1, x2, 8
P 0000007c 00117463  bgeu x2, x1, 8
# jumps, jalr target has bit 0 set
P 00000084 008007ef  jal x15, 8
P 0000008c 09d00813  addi x16, x0, 0x9d
P 00000090 000808e7  jalr x17, 0(x16)
P 0000009c 0041e933  or x18, x3, x4
P 000000a0 004579b3  and x19, x10, x4
P 000000a4 00309a13  slli x20, x1, 3
P 000000a8 00100073  ebreak
# expected register writes in order
E 00000000 01 00000005
E 00000004 02 fffffffd
E 00000008 03 00000002
E 0000000c 04 00000008
E 00000010 05 80000000
E 00000014 06 f8000000
E 00000018 07 08000000
E 0000001c 08 00000001
E 00000020 09 00000000
E 00000024 0a fffffffa
E 00000028 0b 00001028
E 00000030 0c fffffffd
E 00000038 0d 00000000
E 00000084 0f 00000088
E 0000008c 10 0000009d
E 00000090 11 00000094
E 0000009c 12 0000000a
E 000000a0 13 00000008
E 000000a4 14 00000028
H 000000a8

/* verification/core_tb.sv */
/*
  Testbench for core_top. Loads program words and expected retire
  records from the stimulus file, serves them as the instruction ROM,
  checks every retire, the halt pc and the illegal level, and stops
  on a watchdog if the core never reaches ebreak.
*/
`timescale 1ns/1ps

module core_tb;

  import isa_pkg::*;
  import core_pkg::*;

  localparam int rom_words     = 64;
  localparam int clk_period_ns = 40;
  localparam int hold_cycles   = 5;

  logic    clk;
  logic    reset;
  word_t   imem_addr;
  word_t   imem_data;
  logic    retire_valid;
  retire_t retire;
  logic    halt;
  logic    illegal;

  word_t   rom [rom_words];
  retire_t exp_q [$];
  word_t   exp_halt_pc;
  bit      halt_given;
  bit      seen_retire;
  bit      loaded;
  int      prog_words;

  clock_gen u_clock_gen (
    .clk   (clk),
    .reset (reset)
  );

  core_top dut (
    .clk          (clk),
    .reset        (reset),
    .imem_addr    (imem_addr),
    .imem_data    (imem_data),
    .retire_valid (retire_valid),
    .retire       (retire),
    .halt         (halt),
    .illegal      (illegal)
  );

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic compare_retire(input retire_t got, input retire_t exp);
    if (got !== exp) begin
      stop_run($sformatf("[FAIL] %0t retire got pc %h x%0d=%h, expected pc %h x%0d=%h",
                         $time, got.pc, got.rd, got.wdata, exp.pc, exp.rd, exp.wdata));
    end
  endtask

  task automatic compare_halt(input word_t got_pc, input word_t exp_pc);
    if (exp_q.size() != 0) begin
      stop_run($sformatf("[FAIL] %0t halt with %0d expected retires still pending",
                         $time, exp_q.size()));
    end else if (got_pc !== exp_pc) begin
      stop_run($sformatf("[FAIL] %0t halt at pc %h, expected pc %h", $time, got_pc, exp_pc));
    end
  endtask

  task automatic compare_addr(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("[FAIL] %0t %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic compare_level(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("[FAIL] %0t %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  // unlisted words decode as an illegal opcode, so a stray fetch shows up
  task automatic fill_rom();
    logic [24:0] noise;
    for (int i = 0; i < rom_words; i++) begin
      noise  = 25'($urandom());
      rom[i] = {noise ^ 25'(i), 7'h7f};
    end
  endtask

  task automatic parse_record(input string line);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    int          n;
    byte         tag;
    retire_t     rec;
    tag = line.getc(0);
    if (line.len() < 2 || tag == "#") begin
      n = 0;
    end else if (tag == "P") begin
      n = $sscanf(line, "P %h %h", a, b);
      if (n != 2 || a[1:0] != 2'b00 || a >= 4 * rom_words) begin
        stop_run($sformatf("bad program record in stimulus file: %s", line));
      end else begin
        rom[a[7:2]] = b;
        prog_words++;
      end
    end else if (tag == "E") begin
      n = $sscanf(line, "E %h %h %h", a, b, c);
      if (n != 3) begin
        stop_run($sformatf("bad expected record in stimulus file: %s", line));
      end else begin
        rec.pc    = a;
        rec.rd    = b[4:0];
        rec.wdata = c;
        exp_q.push_back(rec);
      end
    end else if (tag == "H") begin
      n = $sscanf(line, "H %h", a);
      if (n != 1) begin
        stop_run($sformatf("bad halt record in stimulus file: %s", line));
      end else begin
        exp_halt_pc = a;
        halt_given  = 1'b1;
      end
    end else begin
      stop_run($sformatf("unknown record in stimulus file: %s", line));
    end
  endtask

  task automatic load_stimulus();
    int    fd;
    int    code;
    string line;
    fd = $fopen("verification/core_stimulus.txt", "r");
    if (fd == 0) begin
      stop_run("could not open verification/core_stimulus.txt");
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 0) begin
          parse_record(line);
        end
      end
      $fclose(fd);
      if (prog_words == 0 || !halt_given) begin
        stop_run("stimulus file has no program words or no halt record");
      end
    end
  endtask

  task automatic check_cycle();
    retire_t expected;
    if (reset) begin
      compare_level(retire_valid, 1'b0, "retire_valid during reset");
    end else begin
      compare_level(illegal, 1'b0, "illegal");
      if (retire_valid) begin
        if (!seen_retire && retire.pc !== pc_reset) begin
          stop_run($sformatf("[FAIL] %0t first retire at pc %h, expected reset pc %h",
                             $time, retire.pc, pc_reset));
        end else if (exp_q.size() == 0) begin
          stop_run($sformatf("[FAIL] %0t unexpected retire at pc %h", $time, retire.pc));
        end else begin
          seen_retire = 1'b1;
          expected    = exp_q.pop_front();
          compare_retire(retire, expected);
        end
      end
    end
  endtask

  // rom answers 1 ns after each edge, once the pc has moved
  initial begin
    imem_data = nop_word;
    forever begin
      @(posedge clk);
      #1;
      imem_data = rom[imem_addr[7:2]];
    end
  end

  initial begin
    void'($urandom(32'h2d22));
    fill_rom();
    load_stimulus();
    loaded = 1'b1;
    do begin
      @(negedge clk);
      check_cycle();
    end while (!(halt && !reset));
    // retire pc follows the executing instruction, here the ebreak
    compare_halt(retire.pc, exp_halt_pc);
    repeat (hold_cycles) begin
      @(negedge clk);
      compare_level(halt, 1'b1, "halt after ebreak");
      compare_level(retire_valid, 1'b0, "retire_valid after halt");
      compare_level(illegal, 1'b0, "illegal");
      // fetch had already stepped past the ebreak when it froze
      compare_addr(imem_addr, exp_halt_pc + 32'd4, "fetch address while halted");
    end
    $display("test passed");
    $finish;
  end

  initial begin : watchdog
    int limit;
    wait (loaded);
    limit = 8 * prog_words + 50;
    #(limit * clk_period_ns);
    stop_run($sformatf("watchdog expired after %0d cycles, the core never halted", limit));
  end

endmodule
